// File: hw/desConsts.svh
// Shared constants for the serial link receiver.
// Word width, FIFO address width, sync pattern and its length.
`ifndef DES_CONSTS_SVH
`define DES_CONSTS_SVH

// --------------------------------------------------
// Parallel side.
// --------------------------------------------------
`define DES_DWID 32        // Bits per data word.
`define DES_AWID 5         // FIFO address bits, depth 32.

// --------------------------------------------------
// Serial framing.
// --------------------------------------------------
// Sync byte goes out MSB first, ahead of the data bits.
`define DES_SYNC 8'hA5     // Sync pattern.
`define DES_SYNC_BITS 8    // Sync length in bits.

// One even-parity bit follows the last data bit.

`endif

// File: hw/desLinkPkg.sv
// Serial link types.
// Decoder FSM encoding and the parallel data word.
`default_nettype none

`include "desConsts.svh"

package desLinkPkg;

  // --------------------------------------------------
  // Decoder FSM.
  // --------------------------------------------------
  // Hunt for sync, shift data, then check parity.
  typedef enum logic [1:0] {
    DecHunt   = 2'd0,  // Sliding sync window.
    DecData   = 2'd1,  // Collecting data bits.
    DecParity = 2'd2   // Waiting on the parity bit.
  } decState_t;

  // --------------------------------------------------
  // Parallel payload.
  // --------------------------------------------------
  // One received word, MSB is the first data bit on the wire.
  typedef logic [`DES_DWID-1:0] parWord_t;

endpackage

`default_nettype wire

// File: hw/desStatusPkg.sv
// Status types.
// FIFO occupancy and the parity error counter.
`default_nettype none

`include "desConsts.svh"

package desStatusPkg;

  // --------------------------------------------------
  // FIFO status.
  // --------------------------------------------------
  // One bit wider than the address so a full FIFO reads 2**AWID.
  typedef logic [`DES_AWID:0] fifoLevel_t;

  // --------------------------------------------------
  // Link errors.
  // --------------------------------------------------
  typedef logic [7:0] errCount_t;  // Saturates at 255.

endpackage

`default_nettype wire

// File: hw/desDecoder.sv
// Frame decoder.
// Sync hunt over a sliding window, serial to parallel shift,
// even parity check and a saturating parity error counter.
`timescale 1ns/1ps
`default_nettype none

`include "desConsts.svh"

module desDecoder
  (
    input  wire                      ParOutClk,
    input  wire                      Reset,
    input  wire                      SerIn,          // Sampled serial bit.
    input  wire                      SerValid,       // Qualifies SerIn.
    output desLinkPkg::parWord_t     DecWord,        // Checked word.
    output logic                     DecValid,       // One-cycle write strobe.
    output desStatusPkg::errCount_t  ParityErrCount  // Bad words seen.
  );

  localparam int CntWid = $clog2(`DES_DWID);  // Data bit counter width.

  // --------------------------------------------------
  // State and datapath registers.
  // --------------------------------------------------
  desLinkPkg::decState_t        state;
  logic [`DES_SYNC_BITS-1:0]    syncWin;   // Last valid bits seen in hunt.
  logic [`DES_SYNC_BITS-1:0]    syncNext;  // Window with the current bit.
  logic [CntWid-1:0]            bitCnt;    // Data bits taken so far.
  logic                         parAcc;    // XOR of the data bits.
  logic                         parityOk;  // Data plus parity bit is even.
  logic                         lastData;  // Final data bit this cycle.
  desLinkPkg::parWord_t         dataSr;    // Data shift register.

  assign syncNext = {syncWin[`DES_SYNC_BITS-2:0], SerIn};
  assign parityOk = ~(parAcc ^ SerIn);
  assign lastData = (bitCnt == CntWid'(`DES_DWID - 1));

  // --------------------------------------------------
  // Control FSM.
  // --------------------------------------------------
  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      state          <= desLinkPkg::DecHunt;
      syncWin        <= '0;
      bitCnt         <= '0;
      parAcc         <= 1'b0;
      DecValid       <= 1'b0;
      ParityErrCount <= '0;
    end
    else
    begin
      DecValid <= 1'b0;  // Strobe lasts one cycle.
      if (SerValid)
      begin
        case (state)
          desLinkPkg::DecHunt:
          begin
            if (syncNext == `DES_SYNC)
            begin
              state   <= desLinkPkg::DecData;
              syncWin <= '0;       // Fresh window after the frame.
              bitCnt  <= '0;
              parAcc  <= 1'b0;
            end
            else
            begin
              syncWin <= syncNext; // Keep sliding.
            end
          end
          desLinkPkg::DecData:
          begin
            parAcc <= parAcc ^ SerIn;
            bitCnt <= bitCnt + 1'b1;
            if (lastData)
            begin
              state <= desLinkPkg::DecParity;
            end
          end
          desLinkPkg::DecParity:
          begin
            if (parityOk)
            begin
              DecValid <= 1'b1;    // Word goes to the FIFO.
            end
            else if (ParityErrCount != 8'hFF)
            begin
              ParityErrCount <= ParityErrCount + 1'b1;
            end
            state <= desLinkPkg::DecHunt;  // Back to hunt either way.
          end
          default:
          begin
            state <= desLinkPkg::DecHunt;  // Unused encoding.
          end
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Payload.
  // --------------------------------------------------
  // Data bits arrive MSB first, so shift in at the bottom.
  always_ff @(posedge ParOutClk)
  begin
    if (SerValid && (state == desLinkPkg::DecData))
    begin
      dataSr <= {dataSr[`DES_DWID-2:0], SerIn};
    end
  end

  // Captured together with the DecValid strobe.
  always_ff @(posedge ParOutClk)
  begin
    if (SerValid && (state == desLinkPkg::DecParity) && parityOk)
    begin
      DecWord <= dataSr;
    end
  end

endmodule

`default_nettype wire

// File: hw/parFifo.sv
// Synchronous FIFO.
// Circular memory, wrap-bit pointers, full and empty flags
// and an occupancy count. Head word shows without a read.
`timescale 1ns/1ps
`default_nettype none

`include "desConsts.svh"

module parFifo
  #(
    parameter int AWid = `DES_AWID,  // Address bits.
    parameter int DWid = `DES_DWID   // Stored word width.
  )
  (
    input  wire                       ParOutClk,
    input  wire                       Reset,
    input  wire desLinkPkg::parWord_t Din,    // Write data.
    input  wire                       Write,  // Push strobe.
    input  wire                       Read,   // Pop strobe.
    output desLinkPkg::parWord_t      Dout,   // Head word.
    output logic                      Full,
    output logic                      Empty,
    output desStatusPkg::fifoLevel_t  Level   // Words held.
  );

  localparam int Depth = 1 << AWid;

  // --------------------------------------------------
  // Storage and pointers.
  // --------------------------------------------------
  logic [DWid-1:0] mem [Depth];  // Word storage.
  logic [AWid:0]   wrPtr;        // MSB is the wrap bit.
  logic [AWid:0]   rdPtr;
  logic            doWrite;      // Accepted push.
  logic            doRead;       // Accepted pop.

  assign doWrite = Write && !Full;   // Push into a full FIFO is lost.
  assign doRead  = Read && !Empty;   // Pop from empty does nothing.

  // --------------------------------------------------
  // Flags and level.
  // --------------------------------------------------
  // Same address with different wrap bits means full.
  assign Empty = (wrPtr == rdPtr);
  assign Full  = (wrPtr[AWid] != rdPtr[AWid]) &&
                 (wrPtr[AWid-1:0] == rdPtr[AWid-1:0]);
  // Pointer distance, so push plus pop leaves it alone.
  assign Level = desStatusPkg::fifoLevel_t'(wrPtr - rdPtr);

  assign Dout = desLinkPkg::parWord_t'(mem[rdPtr[AWid-1:0]]);

  // --------------------------------------------------
  // Pointer update.
  // --------------------------------------------------
  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // Memory write.
  always_ff @(posedge ParOutClk)
  begin
    if (doWrite)
    begin
      mem[wrPtr[AWid-1:0]] <= DWid'(Din);
    end
  end

endmodule

`default_nettype wire

// File: hw/deserializer.sv
// Receiver top level.
// Frame decoder feeding the word FIFO, plus the registered
// output buffer driven by the read command.
`timescale 1ns/1ps
`default_nettype none

module deserializer
  (
    input  wire                      ParOutClk,       // Single clock.
    input  wire                      Reset,
    input  wire                      SerialIn,        // Sampled link bit.
    input  wire                      SerValid,        // Bit qualifier.
    input  wire                      FIFOReadCmd,     // Read request.
    output desLinkPkg::parWord_t     ParOut,          // Delivered word.
    output logic                     ParValid,        // One-cycle valid.
    output logic                     FIFOEmpty,
    output logic                     FIFOFull,
    output desStatusPkg::fifoLevel_t FIFOLevel,
    output desStatusPkg::errCount_t  ParityErrCount
  );

  // --------------------------------------------------
  // Internal nets.
  // --------------------------------------------------
  desLinkPkg::parWord_t DecWord;   // Decoder to FIFO.
  logic                 DecValid;  // FIFO write strobe.
  desLinkPkg::parWord_t FifoHead;  // Current FIFO head.
  logic                 fifoPop;   // Accepted read.

  // Only a read against a non-empty FIFO counts.
  assign fifoPop = FIFOReadCmd && !FIFOEmpty;

  // --------------------------------------------------
  // Frame decoder.
  // --------------------------------------------------
  // Never stalled, a full FIFO just drops the word.
  desDecoder decoder0
    (
      .ParOutClk      (ParOutClk),
      .Reset          (Reset),
      .SerIn          (SerialIn),
      .SerValid       (SerValid),
      .DecWord        (DecWord),
      .DecValid       (DecValid),
      .ParityErrCount (ParityErrCount)
    );

  // --------------------------------------------------
  // Word FIFO.
  // --------------------------------------------------
  parFifo fifo0
    (
      .ParOutClk (ParOutClk),
      .Reset     (Reset),
      .Din       (DecWord),
      .Write     (DecValid),
      .Read      (fifoPop),
      .Dout      (FifoHead),
      .Full      (FIFOFull),
      .Empty     (FIFOEmpty),
      .Level     (FIFOLevel)
    );

  // --------------------------------------------------
  // Output buffer.
  // --------------------------------------------------
  // Head word is captured on the same edge that pops it.
  // ParOut stays zero whenever ParValid is low.
  always_ff @(posedge ParOutClk or posedge Reset)
  begin
    if (Reset)
    begin
      ParOut   <= '0;
      ParValid <= 1'b0;
    end
    else
    begin
      ParValid <= fifoPop;
      if (fifoPop)
      begin
        ParOut <= FifoHead;  // Word leaves the FIFO.
      end
      else
      begin
        ParOut <= '0;        // Idle or empty read.
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/deserializerTb.sv
// Testbench for the serial link receiver.
// Clock and reset, frame stimulus, queue model of the FIFO,
// per-cycle compare process, typed compare tasks, watchdog.
`timescale 1ns/1ps
`default_nettype none

`include "desConsts.svh"

module deserializerTb;

  localparam int ClkPeriod = 8;
  localparam int Depth     = 1 << `DES_AWID;           // FIFO words.
  localparam int NumFrames = 30 + 20 + 260 + 40 + 40;  // All phases.
  localparam int WatchdogCycles = NumFrames * 50 + 5000;

  // --------------------------------------------------
  // DUT signals.
  // --------------------------------------------------
  logic                      ParOutClk;
  logic                      Reset;
  logic                      SerialIn;
  logic                      SerValid;
  logic                      FIFOReadCmd = 1'b0;  // Owned by the read process.
  desLinkPkg::parWord_t      ParOut;
  logic                      ParValid;
  logic                      FIFOEmpty;
  logic                      FIFOFull;
  desStatusPkg::fifoLevel_t  FIFOLevel;
  desStatusPkg::errCount_t   ParityErrCount;

  // Model state.
  desLinkPkg::parWord_t      modelQ[$];   // Words the FIFO should hold.
  desStatusPkg::errCount_t   modelErrs;   // Expected error count.
  logic                      expValid;    // Expected ParValid.
  desLinkPkg::parWord_t      expWord;     // Expected ParOut.
  logic                      stageValid;  // Good word on its way to the FIFO.
  desLinkPkg::parWord_t      stageWord;
  logic                      parSent;     // Parity bit on the wire.
  desLinkPkg::parWord_t      sentWord;    // Word of the frame in flight.
  logic                      checkOn;
  int                        readMode;    // 0 off, 1 random, 2 held high.
  int                        seed;
  int                        readSeed;

  deserializer dut0
    (
      .ParOutClk      (ParOutClk),
      .Reset          (Reset),
      .SerialIn       (SerialIn),
      .SerValid       (SerValid),
      .FIFOReadCmd    (FIFOReadCmd),
      .ParOut         (ParOut),
      .ParValid       (ParValid),
      .FIFOEmpty      (FIFOEmpty),
      .FIFOFull       (FIFOFull),
      .FIFOLevel      (FIFOLevel),
      .ParityErrCount (ParityErrCount)
    );

  initial
  begin
    ParOutClk = 1'b0;
    forever #(ClkPeriod / 2) ParOutClk = ~ParOutClk;  // 8 ns period.
  end

  // --------------------------------------------------
  // Reference and failure helpers.
  // --------------------------------------------------
  // Parity bit that makes data plus parity even.
  function automatic logic evenParity(input desLinkPkg::parWord_t w);
    return ^w;
  endfunction

  function automatic desLinkPkg::parWord_t randWord();
    logic [31:0] r;
    r = $random(seed);
    return desLinkPkg::parWord_t'(r);
  endfunction

  function automatic logic randBit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic failRun(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first mismatch.");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Run aborted.");
  endtask

  task automatic checkWord(input desLinkPkg::parWord_t got, input desLinkPkg::parWord_t exp);
    if (got !== exp)
      failRun($sformatf("ParOut is %h, expected %h", got, exp));
  endtask

  task automatic checkLevel(input desStatusPkg::fifoLevel_t got,
                            input desStatusPkg::fifoLevel_t exp);
    if (got !== exp)
      failRun($sformatf("FIFOLevel is %0d, expected %0d", got, exp));
  endtask

  task automatic checkErrs(input desStatusPkg::errCount_t got,
                           input desStatusPkg::errCount_t exp);
    if (got !== exp)
      failRun($sformatf("ParityErrCount is %0d, expected %0d", got, exp));
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string name);
    if (got !== exp)
      failRun($sformatf("%s is %b, expected %b", name, got, exp));
  endtask

  // --------------------------------------------------
  // Stimulus.
  // --------------------------------------------------
  // One valid bit, sometimes after a cycle with SerValid low.
  task automatic sendBit(input logic b, input logic gaps, input logic isParity);
    logic [31:0] r;
    r = $random(seed);
    if (gaps && (r[2:0] == 3'd0))
    begin
      SerValid = 1'b0;
      SerialIn = randBit();  // Must be ignored.
      @(posedge ParOutClk);
      #1;
    end
    SerialIn = b;
    SerValid = 1'b1;
    parSent  = isParity;
    @(posedge ParOutClk);
    #1;
    SerValid = 1'b0;
    parSent  = 1'b0;
  endtask

  // Junk of at most 4 bits cannot complete a sync byte early.
  task automatic sendFrame(input desLinkPkg::parWord_t word, input logic corrupt,
                           input logic gaps, input logic junk);
    logic [`DES_SYNC_BITS-1:0] syncByte;
    logic [31:0]               r;
    int                        nJunk;
    int                        i;
    syncByte = `DES_SYNC;
    r        = $random(seed);
    nJunk    = junk ? int'(r[7:0] % 5) : 0;
    sentWord = word;
    for (i = 0; i < nJunk; i++)
      sendBit(randBit(), gaps, 1'b0);
    for (i = `DES_SYNC_BITS - 1; i >= 0; i--)
      sendBit(syncByte[i], gaps, 1'b0);          // Sync, MSB first.
    for (i = `DES_DWID - 1; i >= 0; i--)
      sendBit(word[i], gaps, 1'b0);              // Data, MSB first.
    sendBit(evenParity(word) ^ corrupt, gaps, 1'b1);
  endtask

  // Two edges from parity bit to a readable word.
  task automatic settle();
    repeat (3) @(posedge ParOutClk);
    #1;
  endtask

  task automatic drainFifo();
    int waitCycles;
    readMode   = 2;
    waitCycles = 0;
    while ((modelQ.size() != 0) || stageValid)
    begin
      @(posedge ParOutClk);
      #1;
      waitCycles++;
      if (waitCycles > 4 * Depth)
        abortRun("The FIFO did not drain while reads were held high.");
    end
    readMode = 0;
    repeat (2) @(posedge ParOutClk);
    #1;
  endtask

  // Read command, decided from the mode seen at the edge.
  always @(posedge ParOutClk)
  begin
    int          mode;
    logic [31:0] r;
    mode = readMode;
    r    = $random(readSeed);
    #1;
    case (mode)
      1:       FIFOReadCmd = (r[1:0] == 2'b00);  // About one cycle in four.
      2:       FIFOReadCmd = 1'b1;
      default: FIFOReadCmd = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Model and compare.
  // --------------------------------------------------
  // Inputs are stable at the edge, so the model steps here.
  always @(posedge ParOutClk)
  begin
    int preSize;
    if (Reset)
    begin
      modelQ.delete();
      modelErrs  = '0;
      expValid   = 1'b0;
      expWord    = '0;
      stageValid = 1'b0;
    end
    else
    begin
      preSize  = modelQ.size();
      expValid = FIFOReadCmd && (preSize > 0);   // Empty reads ignored.
      expWord  = '0;
      if (expValid)
        expWord = modelQ.pop_front();
      if (stageValid && (preSize < Depth))
        modelQ.push_back(stageWord);             // Full FIFO drops it.
      stageValid = 1'b0;
      if (parSent && SerValid)
      begin
        if (evenParity(sentWord) == SerialIn)
        begin
          stageValid = 1'b1;
          stageWord  = sentWord;
        end
        else if (modelErrs != 8'hFF)
          modelErrs = modelErrs + 8'd1;          // Saturates at 255.
      end
    end
  end

  // Outputs are settled mid-cycle.
  always @(negedge ParOutClk)
  begin
    if (checkOn)
    begin
      checkFlag(ParValid, expValid, "ParValid");
      checkWord(ParOut, expWord);                // Zero when not valid.
      checkErrs(ParityErrCount, modelErrs);
      checkLevel(FIFOLevel, desStatusPkg::fifoLevel_t'(modelQ.size()));
      checkFlag(FIFOEmpty, modelQ.size() == 0, "FIFOEmpty");
      checkFlag(FIFOFull, modelQ.size() == Depth, "FIFOFull");
    end
  end

  initial
  begin
    #(WatchdogCycles * ClkPeriod);
    abortRun("The simulation timed out before all tests finished.");
  end

  // --------------------------------------------------
  // Test sequence.
  // --------------------------------------------------
  initial
  begin
    int i;
    seed       = 32'hee855804;
    readSeed   = seed ^ 32'h5a5a5a5a;  // Separate stream for reads.
    checkOn    = 1'b0;
    readMode   = 0;
    parSent    = 1'b0;
    sentWord   = '0;
    Reset      = 1'b1;
    SerialIn   = 1'b0;
    SerValid   = 1'b0;
    repeat (5) @(posedge ParOutClk);
    #1;
    Reset   = 1'b0;
    checkOn = 1'b1;

    // Reset state.
    checkFlag(ParValid, 1'b0, "ParValid");
    checkFlag(FIFOEmpty, 1'b1, "FIFOEmpty");
    checkFlag(FIFOFull, 1'b0, "FIFOFull");
    checkLevel(FIFOLevel, '0);
    checkErrs(ParityErrCount, '0);

    // Framing and order, with gaps and junk.
    for (i = 0; i < 30; i++)
      sendFrame(randWord(), 1'b0, 1'b1, 1'b1);
    settle();
    drainFifo();

    // Parity rejection, then a burst long enough to saturate.
    for (i = 0; i < 20; i++)
      sendFrame(randWord(), (i % 3) == 1, 1'b1, 1'b1);
    settle();
    checkErrs(ParityErrCount, modelErrs);
    drainFifo();
    for (i = 0; i < 260; i++)
      sendFrame(randWord(), 1'b1, 1'b0, 1'b0);
    settle();
    checkErrs(ParityErrCount, 8'hFF);

    // Full FIFO, no reads. Later words are lost.
    for (i = 0; i < 40; i++)
      sendFrame(randWord(), 1'b0, 1'b0, 1'b1);
    settle();
    checkFlag(FIFOFull, 1'b1, "FIFOFull");
    checkLevel(FIFOLevel, desStatusPkg::fifoLevel_t'(Depth));
    drainFifo();

    // Reads held high on an empty FIFO.
    readMode = 2;
    repeat (10) @(posedge ParOutClk);
    #1;
    readMode = 0;
    settle();

    // Concurrent traffic with random reads.
    readMode = 1;
    for (i = 0; i < 40; i++)
    begin
      sendFrame(randWord(), (i % 5) == 4, 1'b1, 1'b1);
      checkLevel(FIFOLevel, desStatusPkg::fifoLevel_t'(modelQ.size()));
    end
    settle();
    drainFifo();
    checkFlag(FIFOEmpty, 1'b1, "FIFOEmpty");

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/desLinkPkg.sv
hw/desStatusPkg.sv
hw/desDecoder.sv
hw/parFifo.sv
hw/deserializer.sv
bench/deserializerTb.sv

// File: run.sh
#!/bin/sh
# Build the deserializer testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module deserializerTb -f sim.f -o simDes

# The testbench stops with a nonzero status on failure, so keep the output.
out=$(./obj_dir/simDes 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^NO ERRORS$"; then
  echo "Simulation passed."
  exit 0
else
  echo "Simulation failed."
  exit 1
fi
